// File: design/ps2_pkg.sv
package ps2_pkg;

    // one scan code as carried in a PS/2 frame
    localparam int scan_width = 8;

    // the keyboard sends this prefix before the code of a released key
    localparam logic [scan_width-1:0] break_code = 8'hF0;

    // start, eight data bits, odd parity, stop
    localparam int frame_bits = 11;

    // flip-flops between the PS/2 pins and the system clock domain
    localparam int sync_stages = 2;

    // the *_ack states hold code_ack high until code_req drops,
    // and the *_rel states are the single cycle after ack falls
    typedef enum logic [2:0] {
        idle,
        make_ack,
        make_rel,
        brk_ack,
        brk_rel,
        brk_wait,
        code_ack,
        code_rel
    } dec_state_t;

endpackage

// File: design/disp_pkg.sv
package disp_pkg;

    // segments a to g in bits 0 to 6, the dot in bit 7
    localparam int seg_width = 8;

    // digits are active low, so all ones leaves the digit dark
    localparam logic [seg_width-1:0] seg_blank = '1;

    // hex glyphs 0 to F with the dot kept off
    localparam logic [seg_width-1:0] hex_font [16] = '{
        8'hC0,
        8'hF9,
        8'hA4,
        8'hB0,
        8'h99,
        8'h92,
        8'h82,
        8'hF8,
        8'h80,
        8'h90,
        8'h88,
        8'h83,
        8'hC6,
        8'hA1,
        8'h86,
        8'h8E
    };

endpackage

// File: design/ps2_receiver.sv
`timescale 1ns/100ps

module ps2_receiver
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           ps2_clk,
    input  logic                           ps2_dat,
    output logic                           code_req,
    output logic [ps2_pkg::scan_width-1:0] code_data,
    input  logic                           code_ack,
    output logic                           frame_error
);

    import ps2_pkg::*;

    logic [sync_stages-1:0]        clk_sync;
    logic [sync_stages-1:0]        dat_sync;
    logic                          clk_prev;
    logic                          clk_fall;
    logic [$clog2(frame_bits)-1:0] bit_cnt;
    logic                          last_bit;
    logic [frame_bits-1:0]         frame_sr;
    logic                          frame_done;
    logic                          start_ok;
    logic                          parity_ok;
    logic                          stop_ok;
    logic                          frame_good;
    logic                          hs_open;
    logic                          accept;

    // both lines idle high, so the chains start at one and no
    // false edge is seen when reset is released
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= '1;
            dat_sync <= '1;
            clk_prev <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[sync_stages-2:0], ps2_clk};
            dat_sync <= {dat_sync[sync_stages-2:0], ps2_dat};
            clk_prev <= clk_sync[sync_stages-1];
        end
    end

    // the keyboard changes data on the rising edge, we sample on the falling one
    assign clk_fall = clk_prev & ~clk_sync[sync_stages-1];
    assign last_bit = (int'(bit_cnt) == frame_bits - 1);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= clk_fall & last_bit;
            if (clk_fall)
            begin
                if (last_bit)
                begin
                    bit_cnt <= '0;
                end
                else
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // bits arrive lsb first, so after a full frame the start bit sits in bit 0
    always_ff @(posedge clk)
    begin
        if (clk_fall)
        begin
            frame_sr <= {dat_sync[sync_stages-1], frame_sr[frame_bits-1:1]};
        end
    end

    assign start_ok   = ~frame_sr[0];
    assign parity_ok  = ^frame_sr[frame_bits-2:1];
    assign stop_ok    = frame_sr[frame_bits-1];
    assign frame_good = start_ok & parity_ok & stop_ok;

    // a handshake stays open until both req and ack are low again
    assign hs_open = code_req | code_ack;
    assign accept  = frame_done & frame_good & ~hs_open;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            code_req    <= 1'b0;
            frame_error <= 1'b0;
        end
        else
        begin
            if (code_req && code_ack)
            begin
                code_req <= 1'b0;
            end
            if (accept)
            begin
                code_req <= 1'b1;
            end
            else if (frame_done)
            begin
                // a bad frame, or a good one that found the handshake busy
                frame_error <= 1'b1;
            end
        end
    end

    // only loaded while code_req is low, so it is stable for the decoder
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            code_data <= frame_sr[scan_width:1];
        end
    end

endmodule

// File: design/scan_decoder.sv
`timescale 1ns/100ps

module scan_decoder
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           code_req,
    input  logic [ps2_pkg::scan_width-1:0] code_data,
    output logic                           code_ack,
    output logic [ps2_pkg::scan_width-1:0] key_code,
    output logic                           key_shown
);

    import ps2_pkg::*;

    dec_state_t state;

    // the port code_ack hides the state of the same name, which is
    // therefore written with its package scope
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state     <= idle;
            key_code  <= '0;
            key_shown <= 1'b0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (code_req)
                    begin
                        if (code_data == break_code)
                        begin
                            state <= brk_ack;
                        end
                        else
                        begin
                            state     <= make_ack;
                            key_code  <= code_data;
                            key_shown <= 1'b1;
                        end
                    end
                end
                make_ack:
                begin
                    if (!code_req)
                    begin
                        state <= make_rel;
                    end
                end
                make_rel:
                begin
                    state <= idle;
                end
                brk_ack:
                begin
                    if (!code_req)
                    begin
                        state <= brk_rel;
                    end
                end
                brk_rel:
                begin
                    state <= brk_wait;
                end
                brk_wait:
                begin
                    // the released key's code is swallowed, key_code keeps its value
                    if (code_req)
                    begin
                        state     <= ps2_pkg::code_ack;
                        key_shown <= 1'b0;
                    end
                end
                ps2_pkg::code_ack:
                begin
                    if (!code_req)
                    begin
                        state <= code_rel;
                    end
                end
                code_rel:
                begin
                    state <= idle;
                end
                default:
                begin
                    state <= idle;
                end
            endcase
        end
    end

    assign code_ack = (state == make_ack) || (state == brk_ack) ||
                      (state == ps2_pkg::code_ack);

endmodule

// File: design/key_display.sv
`timescale 1ns/100ps

module key_display
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic [ps2_pkg::scan_width-1:0] key_code,
    input  logic                           key_shown,
    output logic [disp_pkg::seg_width-1:0] seg_lo,
    output logic [disp_pkg::seg_width-1:0] seg_hi
);

    import ps2_pkg::*;
    import disp_pkg::*;

    logic [3:0]           nib_lo;
    logic [3:0]           nib_hi;
    logic [seg_width-1:0] lo_next;
    logic [seg_width-1:0] hi_next;

    assign nib_lo = key_code[3:0];
    assign nib_hi = key_code[scan_width-1:4];

    // both digits go dark together once the key is released
    always_comb
    begin
        if (key_shown)
        begin
            lo_next = hex_font[nib_lo];
            hi_next = hex_font[nib_hi];
        end
        else
        begin
            lo_next = seg_blank;
            hi_next = seg_blank;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            seg_lo <= seg_blank;
            seg_hi <= seg_blank;
        end
        else
        begin
            seg_lo <= lo_next;
            seg_hi <= hi_next;
        end
    end

endmodule

// File: design/ps2_key_top.sv
`timescale 1ns/100ps

module ps2_key_top
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           ps2_clk,
    input  logic                           ps2_dat,
    output logic [disp_pkg::seg_width-1:0] seg_lo,
    output logic [disp_pkg::seg_width-1:0] seg_hi,
    output logic                           frame_error
);

    import ps2_pkg::*;

    logic                  code_req;
    logic                  code_ack;
    logic [scan_width-1:0] code_data;
    logic [scan_width-1:0] key_code;
    logic                  key_shown;

    ps2_receiver ps2_receiver_i
    (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_dat     (ps2_dat),
        .code_req    (code_req),
        .code_data   (code_data),
        .code_ack    (code_ack),
        .frame_error (frame_error)
    );

    scan_decoder scan_decoder_i
    (
        .clk       (clk),
        .rst       (rst),
        .code_req  (code_req),
        .code_data (code_data),
        .code_ack  (code_ack),
        .key_code  (key_code),
        .key_shown (key_shown)
    );

    key_display key_display_i
    (
        .clk       (clk),
        .rst       (rst),
        .key_code  (key_code),
        .key_shown (key_shown),
        .seg_lo    (seg_lo),
        .seg_hi    (seg_hi)
    );

endmodule

// File: verif/ps2_key_tb.sv
`timescale 1ns/100ps

module ps2_key_tb;

    import ps2_pkg::*;
    import disp_pkg::*;

    localparam int clk_half_ns = 2;
    // 40 ns per PS/2 half bit and 60 ns of idle line between frames
    localparam int half_cycles = 10;
    localparam int gap_cycles = 15;
    localparam int frame_ns = frame_bits * 2 * half_cycles * 4 + gap_cycles * 4;
    localparam int num_directed = 10;
    localparam int num_random = 300;
    localparam int timeout_ns = (num_directed + num_random) * frame_ns + 2000;

    logic                 clk;
    logic                 rst;
    logic                 ps2_clk;
    logic                 ps2_dat;
    logic [seg_width-1:0] seg_lo;
    logic [seg_width-1:0] seg_hi;
    logic                 frame_error;

    // reference state, kept by the rules of the PS/2 make and break protocol
    logic [scan_width-1:0] exp_code;
    logic                  exp_shown;
    logic                  brk_pending;
    logic                  exp_error;

    ps2_key_top ps2_key_top_i
    (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_dat     (ps2_dat),
        .seg_lo      (seg_lo),
        .seg_hi      (seg_hi),
        .frame_error (frame_error)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(clk_half_ns) clk = ~clk;
        end
    end

    initial
    begin
        #(timeout_ns);
        $display("timeout: the run did not finish in %0d ns", timeout_ns);
        $display("TESTS FAILED");
        $fatal(1);
    end

    // returns 1 ns after a rising edge so that inputs never change on the edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input logic [7:0] code, input logic bad_parity,
                              input logic bad_stop);
        logic [frame_bits-1:0] bits;
        int                    i;
        bits[0]   = 1'b0;
        bits[8:1] = code;
        // odd parity over the data bits
        bits[9]   = ~(^code) ^ bad_parity;
        bits[10]  = ~bad_stop;
        for (i = 0; i < frame_bits; i++)
        begin
            ps2_dat = bits[i];
            wait_cycles(half_cycles);
            ps2_clk = 1'b0;
            wait_cycles(half_cycles);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
        wait_cycles(gap_cycles);
    endtask

    task automatic update_model(input logic [7:0] code, input logic bad);
        if (bad)
        begin
            exp_error = 1'b1;
        end
        else if (brk_pending)
        begin
            brk_pending = 1'b0;
            exp_shown   = 1'b0;
        end
        else if (code == 8'hF0)
        begin
            brk_pending = 1'b1;
        end
        else
        begin
            exp_code  = code;
            exp_shown = 1'b1;
        end
    endtask

    function automatic logic [seg_width-1:0] expected_seg(input logic [3:0] nib);
        if (exp_shown)
        begin
            return hex_font[nib];
        end
        return seg_blank;
    endfunction

    task automatic compare_value(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
        if (actual !== expected)
        begin
            $display("error at %0t ns: %s expected %h got %h", $time, name,
                     expected, actual);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_outputs();
        compare_value("seg_lo", expected_seg(exp_code[3:0]), seg_lo);
        compare_value("seg_hi", expected_seg(exp_code[7:4]), seg_hi);
        compare_value("frame_error", {7'b0, exp_error}, {7'b0, frame_error});
    endtask

    task automatic run_frame(input logic [7:0] code, input logic bad_parity,
                             input logic bad_stop);
        send_frame(code, bad_parity, bad_stop);
        update_model(code, bad_parity | bad_stop);
        check_outputs();
    endtask

    initial
    begin
        int              n;
        int              pick;
        logic [7:0]      code;
        logic            bad_parity;
        logic            bad_stop;
        rst         = 1'b0;
        ps2_clk     = 1'b1;
        ps2_dat     = 1'b1;
        exp_code    = '0;
        exp_shown   = 1'b0;
        brk_pending = 1'b0;
        exp_error   = 1'b0;
        void'($urandom(1));

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        wait_cycles(4);
        check_outputs();

        // a plain make code lights both digits
        code = 8'($urandom_range(255));
        while (code == break_code || code == 8'h1C)
        begin
            code = 8'($urandom_range(255));
        end
        run_frame(code, 1'b0, 1'b0);

        // release blanks the display, the next press lights it again
        run_frame(break_code, 1'b0, 1'b0);
        run_frame(code, 1'b0, 1'b0);
        run_frame(8'h1C, 1'b0, 1'b0);

        // the same key pressed again after its release shows once more
        run_frame(break_code, 1'b0, 1'b0);
        run_frame(8'h1C, 1'b0, 1'b0);
        run_frame(8'h1C, 1'b0, 1'b0);

        // corrupted frames leave the digits alone and latch the error
        run_frame(8'h3A, 1'b1, 1'b0);
        run_frame(8'h2B, 1'b0, 1'b0);
        run_frame(8'h4D, 1'b0, 1'b1);

        for (n = 0; n < num_random; n++)
        begin
            pick       = $urandom_range(99);
            code       = 8'($urandom_range(255));
            bad_parity = 1'b0;
            bad_stop   = 1'b0;
            if (pick < 15)
            begin
                code = break_code;
            end
            else if (pick < 18)
            begin
                bad_parity = 1'b1;
            end
            else if (pick < 20)
            begin
                bad_stop = 1'b1;
            end
            run_frame(code, bad_parity, bad_stop);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: compile.f
design/ps2_pkg.sv
design/disp_pkg.sv
design/ps2_receiver.sv
design/scan_decoder.sv
design/key_display.sv
design/ps2_key_top.sv
verif/ps2_key_tb.sv

// File: Bender.yml
package:
  name: ps2_key

sources:
  - files:
      - design/ps2_pkg.sv
      - design/disp_pkg.sv
      - design/ps2_receiver.sv
      - design/scan_decoder.sv
      - design/key_display.sv
      - design/ps2_key_top.sv
  - target: test
    files:
      - verif/ps2_key_tb.sv
